//--- hdl/level_mon_pkg.sv
package level_mon_pkg;

  localparam int CHAN_W  = 5;    // channel number width, sets the ram address layout
  localparam int RAM_TOP = 128;  // first wishbone address above the threshold ram

  // checker sequencing, one read and one compare per threshold
  typedef enum logic [1:0] {
    LC_IDLE,
    LC_READ,
    LC_CMP,
    LC_SEND
  } lc_state_e;

  // register map, also used as the registered read selector
  typedef enum logic [15:0] {
    REG_SOFT_VALID = 16'h0080,
    REG_HARD_VALID = 16'h0081,
    REG_SOFT_SRC   = 16'h0082,  // write clears the soft latch
    REG_SOFT_VAL   = 16'h0083,
    REG_HARD_SRC   = 16'h0084,  // write clears the hard latch
    REG_HARD_VAL   = 16'h0085,
    REG_INRANGE_LO = 16'h0086,
    REG_INRANGE_HI = 16'h0087,
    REG_OVERRUN    = 16'h0088
  } wb_reg_e;

endpackage

//--- hdl/adc_sample_capture.sv
`timescale 1ns/1ps

module adc_sample_capture #(
  parameter int ADC_W = 12
) (
  input  logic                              wb_clk_i,
  input  logic                              wb_rst_i,
  input  logic                              adc_strb_i,
  input  logic [level_mon_pkg::CHAN_W-1:0]  adc_channel_i,
  input  logic [ADC_W-1:0]                  adc_result_i,
  input  logic                              smp_done_i,
  output logic                              smp_valid_o,
  output logic [level_mon_pkg::CHAN_W-1:0]  smp_channel_o,
  output logic [ADC_W-1:0]                  smp_value_o,
  output logic [15:0]                       ovr_count_o
);

  logic accept;

  assign accept = adc_strb_i & ~smp_valid_o;  // holder empty

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      smp_valid_o <= 1'b0;
      ovr_count_o <= '0;
    end else begin
      if (smp_done_i) begin
        smp_valid_o <= 1'b0;  // checker is through with it
      end
      if (accept) begin
        smp_valid_o <= 1'b1;
      end else if (adc_strb_i && ovr_count_o != 16'hffff) begin
        // busy, the sample is dropped and only counted
        ovr_count_o <= ovr_count_o + 16'd1;
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (accept) begin
      smp_channel_o <= adc_channel_i;
      smp_value_o   <= adc_result_i;
    end
  end

endmodule

//--- hdl/thresh_ram.sv
`timescale 1ns/1ps

module thresh_ram #(
  parameter int ADC_W = 12
) (
  input  logic                              wb_clk_i,
  input  logic                              ram_we_i,
  input  logic                              ram_wb_rd_i,
  input  logic [level_mon_pkg::CHAN_W+1:0]  ram_addr_i,
  input  logic [ADC_W-1:0]                  ram_wdata_i,
  input  logic                              lc_rd_i,
  input  logic [level_mon_pkg::CHAN_W+1:0]  lc_addr_i,
  output logic [ADC_W-1:0]                  rdata_o,
  output logic                              lc_rvalid_o
);

  import level_mon_pkg::*;

  logic [ADC_W-1:0]  mem [2**(CHAN_W+2)];  // {set, channel, polarity}
  logic [CHAN_W+1:0] rd_addr;

  assign rd_addr = ram_wb_rd_i ? ram_addr_i : lc_addr_i;  // wishbone wins the port

  always_ff @(posedge wb_clk_i) begin
    if (ram_we_i) begin
      mem[ram_addr_i] <= ram_wdata_i;
    end
    rdata_o <= mem[rd_addr];
    // tag follows the data, so the checker knows whose read came back
    lc_rvalid_o <= lc_rd_i & ~ram_wb_rd_i;
  end

endmodule

//--- hdl/level_checker.sv
`timescale 1ns/1ps

module level_checker #(
  parameter int ADC_W = 12
) (
  input  logic                              wb_clk_i,
  input  logic                              wb_rst_i,
  input  logic                              smp_valid_i,
  input  logic [level_mon_pkg::CHAN_W-1:0]  smp_channel_i,
  input  logic [ADC_W-1:0]                  smp_value_i,
  input  logic                              soft_en_i,
  input  logic                              hard_en_i,
  input  logic [ADC_W-1:0]                  rdata_i,
  input  logic                              lc_rvalid_i,
  output logic                              lc_rd_o,
  output logic [level_mon_pkg::CHAN_W+1:0]  lc_addr_o,
  output logic                              smp_done_o,
  output logic                              res_strb_o,
  output logic                              res_soft_hit_o,
  output logic                              res_hard_hit_o,
  output logic                              res_hard_checked_o,
  output logic [level_mon_pkg::CHAN_W-1:0]  res_channel_o,
  output logic [ADC_W-1:0]                  res_value_o
);

  import level_mon_pkg::*;

  lc_state_e  state;
  logic [1:0] idx;   // soft low, soft high, hard low, hard high
  logic       over;

  // low threshold trips below it, high threshold above it, equal is fine
  assign over = idx[0] ? (smp_value_i > rdata_i) : (smp_value_i < rdata_i);

  assign lc_rd_o    = (state == LC_READ);
  assign lc_addr_o  = {idx[1], smp_channel_i, idx[0]};
  assign smp_done_o = (state == LC_SEND);  // frees the holder
  assign res_strb_o = (state == LC_SEND);

  // sample stays held until smp_done, so the result can show it directly
  assign res_channel_o = smp_channel_i;
  assign res_value_o   = smp_value_i;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state              <= LC_IDLE;
      idx                <= 2'd0;
      res_soft_hit_o     <= 1'b0;
      res_hard_hit_o     <= 1'b0;
      res_hard_checked_o <= 1'b0;
    end else begin
      case (state)
        LC_IDLE: begin
          if (smp_valid_i) begin
            state              <= LC_READ;
            idx                <= 2'd0;
            res_soft_hit_o     <= 1'b0;
            res_hard_hit_o     <= 1'b0;
            res_hard_checked_o <= 1'b0;
          end
        end
        LC_READ: begin
          state <= LC_CMP;
        end
        LC_CMP: begin
          if (!lc_rvalid_i) begin
            state <= LC_READ;  // wishbone took the port, ask again
          end else begin
            if (idx[1]) begin
              if (hard_en_i) begin
                res_hard_hit_o     <= res_hard_hit_o | over;
                res_hard_checked_o <= 1'b1;
              end
            end else if (soft_en_i) begin
              res_soft_hit_o <= res_soft_hit_o | over;
            end
            idx   <= idx + 2'd1;
            state <= (idx == 2'd3) ? LC_SEND : LC_READ;
          end
        end
        LC_SEND: begin
          state <= LC_IDLE;
        end
        default: begin
          state <= LC_IDLE;
        end
      endcase
    end
  end

endmodule

//--- hdl/viol_status.sv
`timescale 1ns/1ps

module viol_status #(
  parameter int ADC_W = 12
) (
  input  logic                                 wb_clk_i,
  input  logic                                 wb_rst_i,
  input  logic                                 res_strb_i,
  input  logic                                 res_soft_hit_i,
  input  logic                                 res_hard_hit_i,
  input  logic                                 res_hard_checked_i,
  input  logic [level_mon_pkg::CHAN_W-1:0]     res_channel_i,
  input  logic [ADC_W-1:0]                     res_value_i,
  input  logic                                 clr_soft_i,
  input  logic                                 clr_hard_i,
  output logic                                 soft_viol_o,
  output logic                                 hard_viol_o,
  output logic                                 level_done_o,
  output logic [level_mon_pkg::CHAN_W:0]       soft_src_o,
  output logic [ADC_W-1:0]                     soft_val_o,
  output logic [level_mon_pkg::CHAN_W:0]       hard_src_o,
  output logic [ADC_W-1:0]                     hard_val_o,
  output logic [2**level_mon_pkg::CHAN_W-1:0]  v_in_range_o
);

  import level_mon_pkg::*;

  logic soft_take;
  logic hard_take;

  // only the first violation since the last clear is kept
  assign soft_take = res_strb_i & res_soft_hit_i & ~soft_src_o[CHAN_W] & ~clr_soft_i;
  assign hard_take = res_strb_i & res_hard_hit_i & ~hard_src_o[CHAN_W] & ~clr_hard_i;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      soft_viol_o  <= 1'b0;
      hard_viol_o  <= 1'b0;
      level_done_o <= 1'b0;
      soft_src_o   <= '0;
      hard_src_o   <= '0;
      v_in_range_o <= '0;
    end else begin
      soft_viol_o  <= res_strb_i & res_soft_hit_i;
      hard_viol_o  <= res_strb_i & res_hard_hit_i;
      level_done_o <= res_strb_i;
      if (clr_soft_i) begin
        soft_src_o <= '0;
      end else if (soft_take) begin
        soft_src_o <= {1'b1, res_channel_i};
      end
      if (clr_hard_i) begin
        hard_src_o <= '0;
      end else if (hard_take) begin
        hard_src_o <= {1'b1, res_channel_i};
      end
      if (res_strb_i && res_hard_checked_i) begin
        v_in_range_o[res_channel_i] <= ~res_hard_hit_i;
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (soft_take) soft_val_o <= res_value_i;
    if (hard_take) hard_val_o <= res_value_i;
  end

endmodule

//--- hdl/wb_level_regs.sv
`timescale 1ns/1ps

module wb_level_regs (
  input  logic                                 wb_clk_i,
  input  logic                                 wb_rst_i,
  input  logic                                 wb_cyc_i,
  input  logic                                 wb_stb_i,
  input  logic                                 wb_we_i,
  input  logic [15:0]                          wb_adr_i,
  input  logic [15:0]                          wb_dat_i,
  input  logic                                 soft_reset_i,
  input  logic [15:0]                          rdata_i,
  input  logic [level_mon_pkg::CHAN_W:0]       soft_src_i,
  input  logic [15:0]                          soft_val_i,
  input  logic [level_mon_pkg::CHAN_W:0]       hard_src_i,
  input  logic [15:0]                          hard_val_i,
  input  logic [2**level_mon_pkg::CHAN_W-1:0]  v_in_range_i,
  input  logic [15:0]                          ovr_count_i,
  output logic [15:0]                          wb_dat_o,
  output logic                                 wb_ack_o,
  output logic                                 ram_we_o,
  output logic                                 ram_wb_rd_o,
  output logic [level_mon_pkg::CHAN_W+1:0]     ram_addr_o,
  output logic [15:0]                          ram_wdata_o,
  output logic                                 soft_en_o,
  output logic                                 hard_en_o,
  output logic                                 clr_soft_o,
  output logic                                 clr_hard_o
);

  import level_mon_pkg::*;

  logic    wb_trans;
  logic    wb_ram;
  logic    rd_ram;   // current ack returns ram data
  wb_reg_e adr_sel;
  wb_reg_e rd_sel;

  assign wb_trans = wb_cyc_i & wb_stb_i & ~wb_ack_o;  // new transfer
  assign wb_ram   = (wb_adr_i < 16'(RAM_TOP));
  assign adr_sel  = wb_reg_e'(wb_adr_i);

  assign ram_we_o    = wb_trans & wb_ram & wb_we_i;
  assign ram_wb_rd_o = wb_trans & wb_ram & ~wb_we_i;  // takes the read port from the checker
  assign ram_addr_o  = wb_adr_i[CHAN_W+1:0];
  assign ram_wdata_o = wb_dat_i;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_ack_o   <= 1'b0;
      soft_en_o  <= 1'b0;
      hard_en_o  <= 1'b0;
      clr_soft_o <= 1'b0;
      clr_hard_o <= 1'b0;
    end else begin
      wb_ack_o   <= wb_trans;  // single cycle ack
      clr_soft_o <= 1'b0;
      clr_hard_o <= 1'b0;
      if (wb_trans && wb_we_i && !wb_ram) begin
        case (adr_sel)
          REG_SOFT_VALID: soft_en_o  <= wb_dat_i[0];
          REG_HARD_VALID: hard_en_o  <= wb_dat_i[0];
          REG_SOFT_SRC:   clr_soft_o <= 1'b1;
          REG_HARD_SRC:   clr_hard_o <= 1'b1;
          default: ;
        endcase
      end
      if (soft_reset_i) begin
        soft_en_o <= 1'b0;  // overrides a write in the same cycle
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_trans) begin
      rd_ram <= wb_ram;
      rd_sel <= adr_sel;
    end
  end

  // read data lines up with ack
  always_comb begin
    if (rd_ram) begin
      wb_dat_o = rdata_i;
    end else begin
      case (rd_sel)
        REG_SOFT_VALID: wb_dat_o = {15'd0, soft_en_o};
        REG_HARD_VALID: wb_dat_o = {15'd0, hard_en_o};
        REG_SOFT_SRC:   wb_dat_o = 16'(soft_src_i);
        REG_SOFT_VAL:   wb_dat_o = soft_val_i;
        REG_HARD_SRC:   wb_dat_o = 16'(hard_src_i);
        REG_HARD_VAL:   wb_dat_o = hard_val_i;
        REG_INRANGE_LO: wb_dat_o = v_in_range_i[15:0];
        REG_INRANGE_HI: wb_dat_o = v_in_range_i[31:16];
        REG_OVERRUN:    wb_dat_o = ovr_count_i;
        default:        wb_dat_o = 16'd0;  // unused addresses
      endcase
    end
  end

endmodule

//--- hdl/level_mon_top.sv
`timescale 1ns/1ps

module level_mon_top #(
  parameter int ADC_W = 12
) (
  input  logic                              wb_clk_i,
  input  logic                              wb_rst_i,
  input  logic                              wb_cyc_i,
  input  logic                              wb_stb_i,
  input  logic                              wb_we_i,
  input  logic [15:0]                       wb_adr_i,
  input  logic [15:0]                       wb_dat_i,
  output logic [15:0]                       wb_dat_o,
  output logic                              wb_ack_o,
  input  logic                              adc_strb_i,
  input  logic [level_mon_pkg::CHAN_W-1:0]  adc_channel_i,
  input  logic [ADC_W-1:0]                  adc_result_i,
  input  logic                              soft_reset_i,
  output logic                              soft_viol_o,
  output logic                              hard_viol_o,
  output logic                              level_done_o,
  output logic [31:0]                       v_in_range_o
);

  import level_mon_pkg::*;

  localparam int PAD = 16 - ADC_W;  // zero fill up to the bus width

  logic              smp_valid, smp_done;
  logic [CHAN_W-1:0] smp_channel;
  logic [ADC_W-1:0]  smp_value;
  logic [15:0]       ovr_count;
  logic              ram_we, ram_wb_rd, lc_rd, lc_rvalid;
  logic [CHAN_W+1:0] ram_addr, lc_addr;
  logic [15:0]       ram_wdata;
  logic [ADC_W-1:0]  rdata;
  logic              soft_en, hard_en, clr_soft, clr_hard;
  logic              res_strb, res_soft_hit, res_hard_hit, res_hard_checked;
  logic [CHAN_W-1:0] res_channel;
  logic [ADC_W-1:0]  res_value;
  logic [CHAN_W:0]   soft_src, hard_src;
  logic [ADC_W-1:0]  soft_val, hard_val;

  adc_sample_capture #(.ADC_W(ADC_W)) adc_sample_capture_i (
    .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
    .adc_strb_i(adc_strb_i), .adc_channel_i(adc_channel_i), .adc_result_i(adc_result_i),
    .smp_done_i(smp_done), .smp_valid_o(smp_valid), .smp_channel_o(smp_channel),
    .smp_value_o(smp_value), .ovr_count_o(ovr_count)
  );

  thresh_ram #(.ADC_W(ADC_W)) thresh_ram_i (
    .wb_clk_i(wb_clk_i), .ram_we_i(ram_we), .ram_wb_rd_i(ram_wb_rd),
    .ram_addr_i(ram_addr), .ram_wdata_i(ram_wdata[ADC_W-1:0]),
    .lc_rd_i(lc_rd), .lc_addr_i(lc_addr), .rdata_o(rdata), .lc_rvalid_o(lc_rvalid)
  );

  level_checker #(.ADC_W(ADC_W)) level_checker_i (
    .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
    .smp_valid_i(smp_valid), .smp_channel_i(smp_channel), .smp_value_i(smp_value),
    .soft_en_i(soft_en), .hard_en_i(hard_en), .rdata_i(rdata), .lc_rvalid_i(lc_rvalid),
    .lc_rd_o(lc_rd), .lc_addr_o(lc_addr), .smp_done_o(smp_done), .res_strb_o(res_strb),
    .res_soft_hit_o(res_soft_hit), .res_hard_hit_o(res_hard_hit),
    .res_hard_checked_o(res_hard_checked), .res_channel_o(res_channel),
    .res_value_o(res_value)
  );

  viol_status #(.ADC_W(ADC_W)) viol_status_i (
    .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
    .res_strb_i(res_strb), .res_soft_hit_i(res_soft_hit), .res_hard_hit_i(res_hard_hit),
    .res_hard_checked_i(res_hard_checked), .res_channel_i(res_channel),
    .res_value_i(res_value), .clr_soft_i(clr_soft), .clr_hard_i(clr_hard),
    .soft_viol_o(soft_viol_o), .hard_viol_o(hard_viol_o), .level_done_o(level_done_o),
    .soft_src_o(soft_src), .soft_val_o(soft_val), .hard_src_o(hard_src),
    .hard_val_o(hard_val), .v_in_range_o(v_in_range_o)
  );

  wb_level_regs wb_level_regs_i (
    .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
    .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
    .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .soft_reset_i(soft_reset_i),
    .rdata_i({{PAD{1'b0}}, rdata}),
    .soft_src_i(soft_src), .soft_val_i({{PAD{1'b0}}, soft_val}),
    .hard_src_i(hard_src), .hard_val_i({{PAD{1'b0}}, hard_val}),
    .v_in_range_i(v_in_range_o), .ovr_count_i(ovr_count),
    .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
    .ram_we_o(ram_we), .ram_wb_rd_o(ram_wb_rd), .ram_addr_o(ram_addr),
    .ram_wdata_o(ram_wdata), .soft_en_o(soft_en), .hard_en_o(hard_en),
    .clr_soft_o(clr_soft), .clr_hard_o(clr_hard)
  );

endmodule

//--- tests/level_mon_sva.sv
`timescale 1ns/1ps

module level_mon_sva (
  input  logic                     wb_clk_i,
  input  logic                     wb_rst_i,
  input  logic                     cyc_i,
  input  logic                     stb_i,
  input  logic                     ack_i,
  input  logic                     smp_done_i,
  input  level_mon_pkg::lc_state_e state_i,
  input  logic                     soft_viol_i,
  input  logic                     hard_viol_i,
  input  logic                     level_done_i
);

  import level_mon_pkg::*;

  ack_one_cycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    ack_i |=> !ack_i)
    else $error("wishbone ack held for more than one cycle");

  ack_after_transfer: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    ack_i |-> $past(cyc_i && stb_i && !ack_i))
    else $error("wishbone ack without a transfer");

  done_in_send: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    smp_done_i |-> state_i == LC_SEND)
    else $error("smp_done outside LC_SEND");

  // violation pulses only ever come with the end of a check
  viol_with_done: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (soft_viol_i || hard_viol_i) |-> level_done_i)
    else $error("violation pulse without level_done");

endmodule

bind wb_level_regs level_mon_sva wb_sva_i (
  .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i), .cyc_i(wb_cyc_i), .stb_i(wb_stb_i),
  .ack_i(wb_ack_o), .smp_done_i(1'b0), .state_i(level_mon_pkg::LC_IDLE),
  .soft_viol_i(1'b0), .hard_viol_i(1'b0), .level_done_i(1'b0)
);

bind level_checker level_mon_sva lc_sva_i (
  .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i), .cyc_i(1'b0), .stb_i(1'b0),
  .ack_i(1'b0), .smp_done_i(smp_done_o), .state_i(state),
  .soft_viol_i(1'b0), .hard_viol_i(1'b0), .level_done_i(1'b0)
);

bind viol_status level_mon_sva vs_sva_i (
  .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i), .cyc_i(1'b0), .stb_i(1'b0),
  .ack_i(1'b0), .smp_done_i(1'b0), .state_i(level_mon_pkg::LC_IDLE),
  .soft_viol_i(soft_viol_o), .hard_viol_i(hard_viol_o), .level_done_i(level_done_o)
);

//--- tests/level_mon_tb.sv
`timescale 1ns/1ps

module level_mon_tb;

  import level_mon_pkg::*;

  localparam int ADC_W = 12;

  logic        wb_clk_i;
  logic        wb_rst_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  logic [15:0] wb_adr_i;
  logic [15:0] wb_dat_i;
  logic [15:0] wb_dat_o;
  logic        wb_ack_o;
  logic        adc_strb_i;
  logic [4:0]  adc_channel_i;
  logic [11:0] adc_result_i;
  logic        soft_reset_i;
  logic        soft_viol_o;
  logic        hard_viol_o;
  logic        level_done_o;
  logic [31:0] v_in_range_o;

  // shadow state of the monitor
  logic [11:0] thr_m [128];
  logic        soft_en_m, hard_en_m, busy_m;
  logic [31:0] inrange_m;
  logic        soft_lat_m, hard_lat_m;
  logic [4:0]  soft_ch_m, hard_ch_m;
  logic [11:0] soft_val_m, hard_val_m;
  logic [19:0] exp_q [$];  // {hard checked, hard hit, soft hit, channel, value}
  int          drops_m;
  integer      seed;

  level_mon_top #(.ADC_W(ADC_W)) level_mon_top_i (.*);

  always #4 wb_clk_i = ~wb_clk_i;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  // gives {hard checked, hard hit, soft hit}
  // a sample equal to a threshold never trips it
  function automatic logic [2:0] predict_hits(input logic [4:0] ch, input logic [11:0] val);
    logic s_hit;
    logic h_hit;
    s_hit = soft_en_m && (val < thr_m[{1'b0, ch, 1'b0}] || val > thr_m[{1'b0, ch, 1'b1}]);
    h_hit = hard_en_m && (val < thr_m[{1'b1, ch, 1'b0}] || val > thr_m[{1'b1, ch, 1'b1}]);
    return {hard_en_m, h_hit, s_hit};
  endfunction

  task automatic wb_cycle(input logic we, input logic [15:0] adr, input logic [15:0] dat,
                          output logic [15:0] rd);
    int n;
    @(posedge wb_clk_i);
    #1;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    n = 0;
    do begin
      @(posedge wb_clk_i);
      #1;
      n++;
    end while (!wb_ack_o && n < 16);
    if (!wb_ack_o) begin
      abort_run("no Wishbone ack within 16 cycles");
    end else begin
      rd       = wb_dat_o;  // valid while ack is high
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
    end
  endtask

  task automatic wb_write(input logic [15:0] adr, input logic [15:0] dat);
    logic [15:0] unused;
    wb_cycle(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input logic [15:0] adr, output logic [15:0] rd);
    wb_cycle(1'b0, adr, 16'd0, rd);
  endtask

  task automatic adc_strobe(input logic [4:0] ch, input logic [11:0] val);
    @(posedge wb_clk_i);
    #1;
    adc_strb_i    = 1'b1;
    adc_channel_i = ch;
    adc_result_i  = val;
    if (busy_m) begin
      drops_m++;  // holder still full
    end else begin
      busy_m = 1'b1;
      exp_q.push_back({predict_hits(ch, val), ch, val});
    end
    @(posedge wb_clk_i);
    #1;
    adc_strb_i = 1'b0;
  endtask

  task automatic wait_check_done();
    int n;
    n = 0;
    while (busy_m && n < 64) begin
      @(posedge wb_clk_i);
      n++;
    end
    if (busy_m) abort_run("level_done_o did not arrive within 64 cycles");
  endtask

  task automatic run_samples(input int n);
    logic [4:0]  ch;
    logic [11:0] val;
    logic [2:0]  pick;
    for (int i = 0; i < n; i++) begin
      ch   = $random(seed);
      pick = $random(seed);
      val  = $random(seed);
      if (!pick[2]) val = thr_m[{pick[1], ch, pick[0]}];  // land right on a threshold
      adc_strobe(ch, val);
      wait_check_done();
    end
  endtask

  task automatic clear_latches();
    wb_write(REG_SOFT_SRC, 16'd0);
    wb_write(REG_HARD_SRC, 16'd0);
    soft_lat_m = 1'b0;
    soft_ch_m  = '0;
    hard_lat_m = 1'b0;
    hard_ch_m  = '0;
  endtask

  task automatic check_latches();
    logic [15:0] rd;
    wb_read(REG_SOFT_SRC, rd);
    check_value(rd, {soft_lat_m, soft_ch_m}, "REG_SOFT_SRC");
    if (soft_lat_m) begin
      wb_read(REG_SOFT_VAL, rd);
      check_value(rd, soft_val_m, "REG_SOFT_VAL");
    end
    wb_read(REG_HARD_SRC, rd);
    check_value(rd, {hard_lat_m, hard_ch_m}, "REG_HARD_SRC");
    if (hard_lat_m) begin
      wb_read(REG_HARD_VAL, rd);
      check_value(rd, hard_val_m, "REG_HARD_VAL");
    end
  endtask

  // each finished check against the queued prediction
  always @(negedge wb_clk_i) begin : result_monitor
    logic [19:0] e;
    if (!wb_rst_i && level_done_o) begin
      if (exp_q.size() == 0) begin
        abort_run("level_done_o pulsed with no sample outstanding");
      end else begin
        e = exp_q.pop_front();
        check_value(soft_viol_o, e[17], "soft_viol_o");
        check_value(hard_viol_o, e[18], "hard_viol_o");
        if (e[19]) inrange_m[e[16:12]] = ~e[18];
        check_value(v_in_range_o, inrange_m, "v_in_range_o");
        if (e[17] && !soft_lat_m) begin
          soft_lat_m = 1'b1;
          soft_ch_m  = e[16:12];
          soft_val_m = e[11:0];
        end
        if (e[18] && !hard_lat_m) begin
          hard_lat_m = 1'b1;
          hard_ch_m  = e[16:12];
          hard_val_m = e[11:0];
        end
        busy_m = 1'b0;
      end
    end
  end

  initial begin : stimulus
    logic [15:0] d;
    logic [15:0] rd;
    logic [4:0]  ch;
    logic [11:0] val;
    seed          = 32'h600d;
    wb_clk_i      = 1'b0;
    wb_rst_i      = 1'b1;
    wb_cyc_i      = 1'b0;
    wb_stb_i      = 1'b0;
    wb_we_i       = 1'b0;
    wb_adr_i      = '0;
    wb_dat_i      = '0;
    adc_strb_i    = 1'b0;
    adc_channel_i = '0;
    adc_result_i  = '0;
    soft_reset_i  = 1'b0;
    soft_en_m     = 1'b0;
    hard_en_m     = 1'b0;
    busy_m        = 1'b0;
    inrange_m     = '0;
    soft_lat_m    = 1'b0;
    hard_lat_m    = 1'b0;
    soft_ch_m     = '0;
    hard_ch_m     = '0;
    drops_m       = 0;
    repeat (10) @(posedge wb_clk_i);
    #1;
    wb_rst_i = 1'b0;

    // threshold ram readback
    for (int a = 0; a < RAM_TOP; a++) begin
      d = $random(seed);
      wb_write(a, d);
      thr_m[a] = d[11:0];
    end
    for (int a = 0; a < RAM_TOP; a++) begin
      wb_read(a, rd);
      check_value(rd, {4'd0, thr_m[a]}, "threshold ram readback");
    end

    // low thresholds in the lower half of the range and high ones in the upper half
    for (int a = 0; a < RAM_TOP; a++) begin
      d = $random(seed);
      d = {4'd0, a[0], d[10:0]};
      wb_write(a, d);
      thr_m[a] = d[11:0];
    end

    // both sets on
    wb_write(REG_SOFT_VALID, 16'd1);
    soft_en_m = 1'b1;
    wb_write(REG_HARD_VALID, 16'd1);
    hard_en_m = 1'b1;
    run_samples(40);

    // hard set off and then a soft reset
    wb_write(REG_HARD_VALID, 16'd0);
    hard_en_m = 1'b0;
    run_samples(16);
    wb_write(REG_HARD_VALID, 16'd1);
    hard_en_m = 1'b1;
    @(posedge wb_clk_i);
    #1;
    soft_reset_i = 1'b1;
    @(posedge wb_clk_i);
    #1;
    soft_reset_i = 1'b0;
    soft_en_m    = 1'b0;
    wb_read(REG_SOFT_VALID, rd);
    check_value(rd, 16'd0, "REG_SOFT_VALID after soft reset");
    run_samples(16);

    // first violation latches
    wb_write(REG_SOFT_VALID, 16'd1);
    soft_en_m = 1'b1;
    clear_latches();
    check_latches();
    run_samples(12);
    check_latches();
    clear_latches();
    check_latches();
    run_samples(12);
    check_latches();

    // in-range registers and overrun count
    wb_read(REG_INRANGE_LO, rd);
    check_value(rd, inrange_m[15:0], "REG_INRANGE_LO");
    wb_read(REG_INRANGE_HI, rd);
    check_value(rd, inrange_m[31:16], "REG_INRANGE_HI");
    for (int i = 0; i < 4; i++) begin
      ch  = $random(seed);
      val = $random(seed);
      adc_strobe(ch, val);  // one check lasts longer than these four strobes
    end
    wait_check_done();
    wb_read(REG_OVERRUN, rd);
    check_value(rd, drops_m, "REG_OVERRUN");

    // ram reads stealing the port during a check
    for (int i = 0; i < 8; i++) begin
      ch  = $random(seed);
      val = $random(seed);
      adc_strobe(ch, val);
      for (int j = 0; j < 3; j++) begin
        d = $random(seed) & 16'h007f;
        wb_read(d, rd);
        check_value(rd, {4'd0, thr_m[d[6:0]]}, "threshold read during a check");
      end
      wait_check_done();
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- verilog.f
hdl/level_mon_pkg.sv
hdl/adc_sample_capture.sv
hdl/thresh_ram.sv
hdl/level_checker.sv
hdl/viol_status.sv
hdl/wb_level_regs.sv
hdl/level_mon_top.sv
tests/level_mon_sva.sv
tests/level_mon_tb.sv
